// File: verilog/opnd_macros.svh
`ifndef OPND_MACROS_SVH
`define OPND_MACROS_SVH

// Width of a data word, a register value and an effective address
`define OPND_WORD_W 32

// Instruction byte window, opcode sits in the lowest byte
`define OPND_INSTR_W 88

// Width of one instruction byte
`define OPND_BYTE_W 8

// Register selector width, enough for EAX through EDI
`define OPND_REGSEL_W 3

// Instruction body length, counts bytes after the opcode
`define OPND_LEN_W 4

// Number of general registers in a snapshot
`define OPND_GPR_N 8

// Register selector of the implicit accumulator
`define OPND_REG_EAX 3'd0

`endif

// File: verilog/opnd_pkg.sv
`include "opnd_macros.svh"

package opnd_pkg;

  // Operand encoding form
  // The name lists operand 0 first and then operand 1
  typedef enum logic [2:0] {
    FORM_NONE    = 3'd0,
    FORM_REG     = 3'd1,
    FORM_RM_REG  = 3'd2,
    FORM_REG_RM  = 3'd3,
    FORM_RM_IMM  = 3'd4,
    FORM_EAX_IMM = 3'd5,
    FORM_IMM     = 3'd6
  } opnd_form_e;

  // What an operand writes back to, if anything
  typedef enum logic [1:0] {
    DEST_NONE = 2'd0,
    DEST_REG  = 2'd1,
    DEST_MEM  = 2'd2
  } dest_kind_e;

  // Where an operand value comes from
  typedef enum logic [1:0] {
    SRC_NONE = 2'd0,
    SRC_REG  = 2'd1,
    SRC_MEM  = 2'd2,
    SRC_IMM  = 2'd3
  } opnd_src_e;

  // Register snapshot indexed by the x86 selector
  // Order is EAX, ECX, EDX, EBX, ESP, EBP, ESI, EDI
  typedef logic [`OPND_GPR_N-1:0][`OPND_WORD_W-1:0] gpr_file_t;

  // One memory access hint from the trace
  typedef struct packed {
    logic                    is_write;
    logic [`OPND_WORD_W-1:0] address;
    logic [`OPND_WORD_W-1:0] data;
  } mem_hint_t;

endpackage

// File: verilog/opnd_stage_if.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

// Decoded fields handed from field extraction to address generation
interface fields_if;
  import opnd_pkg::*;

  logic                       valid;
  opnd_form_e                 form;
  logic [`OPND_BYTE_W-1:0]    modrm;
  logic [`OPND_BYTE_W-1:0]    sib;
  logic                       has_sib;
  // Displacement is sign-extended but only meaningful with disp_present
  logic [`OPND_WORD_W-1:0]    disp;
  logic [`OPND_WORD_W-1:0]    imm;
  logic                       disp_present;
  logic [`OPND_LEN_W-1:0]     body_len;
  logic [`OPND_REGSEL_W-1:0]  opnd_byte;
  logic                       is_lea;
  logic                       opnd0_is_write;
  logic                       opnd1_is_write;
  gpr_file_t                  gpr;
  mem_hint_t                  hint1;
  mem_hint_t                  hint2;

  modport source (output valid, form, modrm, sib, has_sib, disp, imm, disp_present,
                  body_len, opnd_byte, is_lea, opnd0_is_write, opnd1_is_write,
                  gpr, hint1, hint2);
  modport sink   (input valid, form, modrm, sib, has_sib, disp, imm, disp_present,
                  body_len, opnd_byte, is_lea, opnd0_is_write, opnd1_is_write,
                  gpr, hint1, hint2);
endinterface

// Classified operands and the effective address, handed to hint resolution
interface addr_if;
  import opnd_pkg::*;

  logic                       valid;
  opnd_src_e                  opnd0_src;
  opnd_src_e                  opnd1_src;
  logic [`OPND_WORD_W-1:0]    opnd0_regval;
  logic [`OPND_WORD_W-1:0]    opnd1_regval;
  logic [`OPND_REGSEL_W-1:0]  opnd0_regsel;
  logic [`OPND_REGSEL_W-1:0]  opnd1_regsel;
  // Only one memory operand exists per instruction, so one address serves both
  logic [`OPND_WORD_W-1:0]    eff_addr;
  logic [`OPND_WORD_W-1:0]    imm;
  logic                       is_lea;
  logic                       opnd0_is_write;
  logic                       opnd1_is_write;
  mem_hint_t                  hint1;
  mem_hint_t                  hint2;
  logic [`OPND_LEN_W-1:0]     body_len;

  modport source (output valid, opnd0_src, opnd1_src, opnd0_regval, opnd1_regval,
                  opnd0_regsel, opnd1_regsel, eff_addr, imm, is_lea,
                  opnd0_is_write, opnd1_is_write, hint1, hint2, body_len);
  modport sink   (input valid, opnd0_src, opnd1_src, opnd0_regval, opnd1_regval,
                  opnd0_regsel, opnd1_regsel, eff_addr, imm, is_lea,
                  opnd0_is_write, opnd1_is_write, hint1, hint2, body_len);
endinterface

// File: verilog/instr_field_extract.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module instr_field_extract (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     in_valid,
  input  logic [`OPND_INSTR_W-1:0] instr_bytes,
  input  opnd_pkg::opnd_form_e     form,
  input  logic                     imm_1byte,
  input  logic                     is_lea,
  input  logic                     opnd0_is_write,
  input  logic                     opnd1_is_write,
  input  opnd_pkg::gpr_file_t      gpr,
  input  opnd_pkg::mem_hint_t      hint1,
  input  opnd_pkg::mem_hint_t      hint2,
  fields_if.source                 fields
);
  import opnd_pkg::*;

  localparam int LW = `OPND_LEN_W;
  localparam int BW = `OPND_BYTE_W;
  localparam int WW = `OPND_WORD_W;

  // Captured copy of the strobed inputs
  logic                     cap_valid;
  logic [`OPND_INSTR_W-1:0] cap_bytes;
  opnd_form_e               cap_form;
  logic                     cap_imm_1byte;
  logic                     cap_is_lea;
  logic                     cap_wr0;
  logic                     cap_wr1;
  gpr_file_t                cap_gpr;
  mem_hint_t                cap_hint1;
  mem_hint_t                cap_hint2;

  logic          has_modrm;
  logic          has_imm;
  logic          has_sib;
  logic          is_disp8;
  logic          is_disp32;
  logic [BW-1:0] modrm;
  logic [BW-1:0] sib;
  logic [1:0]    mod_f;
  logic [2:0]    rm_f;
  logic [LW-1:0] disp_off;
  logic [LW-1:0] disp_len;
  logic [LW-1:0] imm_off;
  logic [LW-1:0] imm_len;
  logic [`OPND_INSTR_W-1:0] disp_window;
  logic [`OPND_INSTR_W-1:0] imm_window;
  logic [WW-1:0] disp_sext;
  logic [WW-1:0] imm_sext;

  // Captured strobe
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cap_valid <= 1'b0;
    end else begin
      cap_valid <= in_valid;
    end
  end

  // Payload capture follows the inputs on every edge
  always_ff @(posedge clk) begin
    cap_bytes     <= instr_bytes;
    cap_form      <= form;
    cap_imm_1byte <= imm_1byte;
    cap_is_lea    <= is_lea;
    cap_wr0       <= opnd0_is_write;
    cap_wr1       <= opnd1_is_write;
    cap_gpr       <= gpr;
    cap_hint1     <= hint1;
    cap_hint2     <= hint2;
  end

  // Forms that reference r/m carry a ModR/M byte right after the opcode
  assign has_modrm = cap_form inside {FORM_RM_REG, FORM_REG_RM, FORM_RM_IMM};
  assign has_imm   = cap_form inside {FORM_RM_IMM, FORM_EAX_IMM, FORM_IMM};
  assign modrm     = cap_bytes[2*BW-1:BW];
  assign sib       = cap_bytes[3*BW-1:2*BW];
  assign mod_f     = modrm[7:6];
  assign rm_f      = modrm[2:0];

  // rm of 100 in any memory mode escapes to a SIB byte
  assign has_sib  = has_modrm && (mod_f != 2'b11) && (rm_f == 3'b100);
  assign is_disp8 = has_modrm && (mod_f == 2'b01);
  // mod 00 takes a disp32 only in place of a missing base register
  assign is_disp32 = has_modrm && ((mod_f == 2'b10) ||
                                   (mod_f == 2'b00 && rm_f == 3'b101) ||
                                   (mod_f == 2'b00 && has_sib && sib[2:0] == 3'b101));

  assign disp_len = is_disp8 ? LW'(1) : (is_disp32 ? LW'(4) : LW'(0));
  assign imm_len  = !has_imm ? LW'(0) : (cap_imm_1byte ? LW'(1) : LW'(4));

  // Byte offsets are counted from the opcode at byte 0
  assign disp_off = LW'(1) + LW'(has_modrm) + LW'(has_sib);
  assign imm_off  = disp_off + disp_len;

  assign disp_window = cap_bytes >> {disp_off, 3'b000};
  assign imm_window  = cap_bytes >> {imm_off, 3'b000};

  assign disp_sext = is_disp8 ? {{(WW-BW){disp_window[BW-1]}}, disp_window[BW-1:0]}
                              : disp_window[WW-1:0];
  // A missing immediate reads as zero
  assign imm_sext  = !has_imm      ? '0 :
                     cap_imm_1byte ? {{(WW-BW){imm_window[BW-1]}}, imm_window[BW-1:0]}
                                   : imm_window[WW-1:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      fields.valid <= 1'b0;
    end else begin
      fields.valid <= cap_valid;
    end
  end

  always_ff @(posedge clk) begin
    fields.form           <= cap_form;
    fields.modrm          <= modrm;
    fields.sib            <= sib;
    fields.has_sib        <= has_sib;
    fields.disp           <= disp_sext;
    fields.imm            <= imm_sext;
    fields.disp_present   <= is_disp8 || is_disp32;
    // The opcode itself is not part of the body
    fields.body_len       <= LW'(has_modrm) + LW'(has_sib) + disp_len + imm_len;
    fields.opnd_byte      <= cap_bytes[`OPND_REGSEL_W-1:0];
    fields.is_lea         <= cap_is_lea;
    fields.opnd0_is_write <= cap_wr0;
    fields.opnd1_is_write <= cap_wr1;
    fields.gpr            <= cap_gpr;
    fields.hint1          <= cap_hint1;
    fields.hint2          <= cap_hint2;
  end

endmodule

// File: verilog/opnd_address_gen.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module opnd_address_gen (
  input  logic     clk,
  input  logic     rst_n,
  fields_if.sink   fields,
  addr_if.source   addr
);
  import opnd_pkg::*;

  localparam int SW = `OPND_REGSEL_W;
  localparam int WW = `OPND_WORD_W;

  logic [1:0]    mod_f;
  logic [SW-1:0] reg_f;
  logic [SW-1:0] rm_f;
  logic          rm_is_reg;
  opnd_src_e     opnd0_src;
  opnd_src_e     opnd1_src;
  logic [SW-1:0] opnd0_sel;
  logic [SW-1:0] opnd1_sel;
  logic          no_base;
  logic          no_index;
  logic [SW-1:0] base_sel;
  logic [SW-1:0] index_sel;
  logic [WW-1:0] base_val;
  logic [WW-1:0] index_val;
  logic [WW-1:0] disp_val;

  assign mod_f = fields.modrm[7:6];
  assign reg_f = fields.modrm[5:3];
  assign rm_f  = fields.modrm[2:0];

  // mod 11 makes r/m name a register directly instead of memory
  assign rm_is_reg = (mod_f == 2'b11);

  // Classify both operands from the encoding form
  always_comb begin
    opnd0_src = SRC_NONE;
    opnd0_sel = '0;
    opnd1_src = SRC_NONE;
    opnd1_sel = '0;
    case (fields.form)
      FORM_REG: begin
        // Register number is packed into the opcode
        opnd0_src = SRC_REG;
        opnd0_sel = fields.opnd_byte;
      end
      FORM_RM_REG: begin
        opnd0_src = rm_is_reg ? SRC_REG : SRC_MEM;
        opnd0_sel = rm_is_reg ? rm_f : '0;
        opnd1_src = SRC_REG;
        opnd1_sel = reg_f;
      end
      FORM_REG_RM: begin
        opnd0_src = SRC_REG;
        opnd0_sel = reg_f;
        opnd1_src = rm_is_reg ? SRC_REG : SRC_MEM;
        opnd1_sel = rm_is_reg ? rm_f : '0;
      end
      FORM_RM_IMM: begin
        opnd0_src = rm_is_reg ? SRC_REG : SRC_MEM;
        opnd0_sel = rm_is_reg ? rm_f : '0;
        opnd1_src = SRC_IMM;
      end
      FORM_EAX_IMM: begin
        opnd0_src = SRC_REG;
        opnd0_sel = `OPND_REG_EAX;
        opnd1_src = SRC_IMM;
      end
      FORM_IMM: begin
        opnd0_src = SRC_IMM;
      end
      default: begin
        opnd0_src = SRC_NONE;
      end
    endcase
  end

  // Base comes from SIB when present, otherwise from ModR/M.rm
  assign base_sel = fields.has_sib ? fields.sib[2:0] : rm_f;
  // Base 101 under mod 00 means a bare disp32 takes the base's place
  assign no_base  = (mod_f == 2'b00) &&
                    (fields.has_sib ? (fields.sib[2:0] == 3'b101) : (rm_f == 3'b101));
  assign base_val = no_base ? '0 : fields.gpr[base_sel];

  // Index 100 encodes no index, and plain ModR/M never has one
  assign index_sel = fields.sib[5:3];
  assign no_index  = !fields.has_sib || (index_sel == 3'b100);
  assign index_val = no_index ? '0 : (fields.gpr[index_sel] << fields.sib[7:6]);

  assign disp_val = fields.disp_present ? fields.disp : '0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr.valid <= 1'b0;
    end else begin
      addr.valid <= fields.valid;
    end
  end

  always_ff @(posedge clk) begin
    addr.opnd0_src      <= opnd0_src;
    addr.opnd1_src      <= opnd1_src;
    addr.opnd0_regval   <= fields.gpr[opnd0_sel];
    addr.opnd1_regval   <= fields.gpr[opnd1_sel];
    addr.opnd0_regsel   <= opnd0_sel;
    addr.opnd1_regsel   <= opnd1_sel;
    addr.eff_addr       <= base_val + index_val + disp_val;
    addr.imm            <= fields.imm;
    addr.is_lea         <= fields.is_lea;
    addr.opnd0_is_write <= fields.opnd0_is_write;
    addr.opnd1_is_write <= fields.opnd1_is_write;
    addr.hint1          <= fields.hint1;
    addr.hint2          <= fields.hint2;
    addr.body_len       <= fields.body_len;
  end

endmodule

// File: verilog/opnd_hint_resolve.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module opnd_hint_resolve (
  input  logic                       clk,
  input  logic                       rst_n,
  addr_if.sink                       addr,
  output logic                       out_valid,
  output logic [`OPND_LEN_W-1:0]     instr_body_len,
  output logic [`OPND_WORD_W-1:0]    opnd0,
  output logic [`OPND_WORD_W-1:0]    opnd1,
  output opnd_pkg::dest_kind_e       dest0_kind,
  output opnd_pkg::dest_kind_e       dest1_kind,
  output logic [`OPND_REGSEL_W-1:0]  dest0_sel,
  output logic [`OPND_REGSEL_W-1:0]  dest1_sel
);
  import opnd_pkg::*;

  localparam int WW = `OPND_WORD_W;

  logic [WW-1:0] mem_val;
  dest_kind_e    kind0;
  dest_kind_e    kind1;

  // Pick the operand value by its source
  function automatic logic [WW-1:0] pick_value(opnd_src_e src, logic [WW-1:0] regval,
                                               logic [WW-1:0] memval, logic [WW-1:0] immval);
    case (src)
      SRC_REG: pick_value = regval;
      SRC_MEM: pick_value = memval;
      SRC_IMM: pick_value = immval;
      default: pick_value = '0;
    endcase
  endfunction

  // Only written operands report a destination, immediates never do
  function automatic dest_kind_e pick_kind(logic is_write, opnd_src_e src);
    if (!is_write) begin
      pick_kind = DEST_NONE;
    end else if (src == SRC_REG) begin
      pick_kind = DEST_REG;
    end else if (src == SRC_MEM) begin
      pick_kind = DEST_MEM;
    end else begin
      pick_kind = DEST_NONE;
    end
  endfunction

  // LEA wants the address itself, otherwise the first matching read hint wins
  assign mem_val = addr.is_lea ? addr.eff_addr :
                   (!addr.hint1.is_write && addr.hint1.address == addr.eff_addr) ?
                     addr.hint1.data :
                   (!addr.hint2.is_write && addr.hint2.address == addr.eff_addr) ?
                     addr.hint2.data : '0;

  assign kind0 = pick_kind(addr.opnd0_is_write, addr.opnd0_src);
  assign kind1 = pick_kind(addr.opnd1_is_write, addr.opnd1_src);

  // Results load only with a valid item and hold until the next one
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid      <= 1'b0;
      instr_body_len <= '0;
      opnd0          <= '0;
      opnd1          <= '0;
      dest0_kind     <= DEST_NONE;
      dest1_kind     <= DEST_NONE;
      dest0_sel      <= '0;
      dest1_sel      <= '0;
    end else begin
      out_valid <= addr.valid;
      if (addr.valid) begin
        instr_body_len <= addr.body_len;
        opnd0          <= pick_value(addr.opnd0_src, addr.opnd0_regval, mem_val, addr.imm);
        opnd1          <= pick_value(addr.opnd1_src, addr.opnd1_regval, mem_val, addr.imm);
        dest0_kind     <= kind0;
        dest1_kind     <= kind1;
        // Selector is only meaningful for a register destination
        dest0_sel      <= (kind0 == DEST_REG) ? addr.opnd0_regsel : '0;
        dest1_sel      <= (kind1 == DEST_REG) ? addr.opnd1_regsel : '0;
      end
    end
  end

endmodule

// File: verilog/decode_opnds.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module decode_opnds (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       in_valid,
  input  logic [`OPND_INSTR_W-1:0]   instr_bytes,
  input  opnd_pkg::opnd_form_e       form,
  input  logic                       imm_1byte,
  input  logic                       is_lea,
  input  logic                       opnd0_is_write,
  input  logic                       opnd1_is_write,
  input  opnd_pkg::gpr_file_t        gpr,
  input  opnd_pkg::mem_hint_t        hint1,
  input  opnd_pkg::mem_hint_t        hint2,
  output logic                       out_valid,
  output logic [`OPND_LEN_W-1:0]     instr_body_len,
  output logic [`OPND_WORD_W-1:0]    opnd0,
  output logic [`OPND_WORD_W-1:0]    opnd1,
  output opnd_pkg::dest_kind_e       dest0_kind,
  output opnd_pkg::dest_kind_e       dest1_kind,
  output logic [`OPND_REGSEL_W-1:0]  dest0_sel,
  output logic [`OPND_REGSEL_W-1:0]  dest1_sel
);

  // Stage links, extraction to addressing and addressing to hint lookup
  fields_if u_fields ();
  addr_if   u_addr ();

  // Captures the strobe and splits the instruction into fields
  instr_field_extract u_extract (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .instr_bytes    (instr_bytes),
    .form           (form),
    .imm_1byte      (imm_1byte),
    .is_lea         (is_lea),
    .opnd0_is_write (opnd0_is_write),
    .opnd1_is_write (opnd1_is_write),
    .gpr            (gpr),
    .hint1          (hint1),
    .hint2          (hint2),
    .fields         (u_fields.source)
  );

  opnd_address_gen u_agen (
    .clk    (clk),
    .rst_n  (rst_n),
    .fields (u_fields.sink),
    .addr   (u_addr.source)
  );

  // Last stage owns the top-level outputs
  opnd_hint_resolve u_resolve (
    .clk            (clk),
    .rst_n          (rst_n),
    .addr           (u_addr.sink),
    .out_valid      (out_valid),
    .instr_body_len (instr_body_len),
    .opnd0          (opnd0),
    .opnd1          (opnd1),
    .dest0_kind     (dest0_kind),
    .dest1_kind     (dest1_kind),
    .dest0_sel      (dest0_sel),
    .dest1_sel      (dest1_sel)
  );

endmodule

// File: verif/decode_opnds_tb.sv
`timescale 1ns/1ps
`include "opnd_macros.svh"

module decode_opnds_tb;
  import opnd_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 5;
  localparam int LATENCY      = 3;
  localparam int DRAIN_LIMIT  = 64;

  // One outstanding instruction and the outputs it must produce
  typedef struct packed {
    logic [31:0]                cycle;
    logic [`OPND_LEN_W-1:0]     len;
    logic [`OPND_WORD_W-1:0]    op0;
    logic [`OPND_WORD_W-1:0]    op1;
    logic [1:0]                 k0;
    logic [1:0]                 k1;
    logic [`OPND_REGSEL_W-1:0]  s0;
    logic [`OPND_REGSEL_W-1:0]  s1;
  } expect_t;

  logic                       clk;
  logic                       rst_n;
  logic                       in_valid;
  logic [`OPND_INSTR_W-1:0]   instr_bytes;
  opnd_form_e                 form;
  logic                       imm_1byte;
  logic                       is_lea;
  logic                       opnd0_is_write;
  logic                       opnd1_is_write;
  gpr_file_t                  gpr;
  mem_hint_t                  hint1;
  mem_hint_t                  hint2;
  logic                       out_valid;
  logic [`OPND_LEN_W-1:0]     instr_body_len;
  logic [`OPND_WORD_W-1:0]    opnd0;
  logic [`OPND_WORD_W-1:0]    opnd1;
  dest_kind_e                 dest0_kind;
  dest_kind_e                 dest1_kind;
  logic [`OPND_REGSEL_W-1:0]  dest0_sel;
  logic [`OPND_REGSEL_W-1:0]  dest1_sel;

  expect_t     pending[$];
  expect_t     exp_item;
  int unsigned cyc = 0;

  decode_opnds DUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .in_valid       (in_valid),
    .instr_bytes    (instr_bytes),
    .form           (form),
    .imm_1byte      (imm_1byte),
    .is_lea         (is_lea),
    .opnd0_is_write (opnd0_is_write),
    .opnd1_is_write (opnd1_is_write),
    .gpr            (gpr),
    .hint1          (hint1),
    .hint2          (hint2),
    .out_valid      (out_valid),
    .instr_body_len (instr_body_len),
    .opnd0          (opnd0),
    .opnd1          (opnd1),
    .dest0_kind     (dest0_kind),
    .dest1_kind     (dest1_kind),
    .dest0_sel      (dest0_sel),
    .dest1_sel      (dest1_sel)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Counts rising edges so that each result can be timed against its strobe
  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** FAILED ***");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("mismatch at time %0t: %s expected %h actual %h",
                          $time, name, expected, actual));
    end
  endtask

  // Outputs are stable at the falling edge half a cycle after the stage registers load
  always @(negedge clk) begin
    if (rst_n && out_valid) begin
      if (pending.size() == 0) begin
        abort_run("out_valid was raised with no instruction outstanding");
      end else begin
        exp_item = pending.pop_front();
        check("result cycle", exp_item.cycle, 32'(cyc));
        check("instr_body_len", 32'(exp_item.len), 32'(instr_body_len));
        check("opnd0", exp_item.op0, opnd0);
        check("opnd1", exp_item.op1, opnd1);
        check("dest0_kind", 32'(exp_item.k0), 32'(dest0_kind));
        check("dest1_kind", 32'(exp_item.k1), 32'(dest1_kind));
        check("dest0_sel", 32'(exp_item.s0), 32'(dest0_sel));
        check("dest1_sel", 32'(exp_item.s1), 32'(dest1_sel));
      end
    end
  end

  initial begin : drive
    int                     fd;
    int                     n;
    int                     sent;
    int                     waited;
    bit                     have_regs;
    string                  line;
    logic [31:0]            regs [8];
    logic [`OPND_INSTR_W-1:0] bytes_v;
    logic [31:0]            form_v;
    logic [31:0]            flags_v;
    logic [31:0]            hw_v;
    logic [31:0]            h1a_v;
    logic [31:0]            h1d_v;
    logic [31:0]            h2a_v;
    logic [31:0]            h2d_v;
    logic [31:0]            idle_v;
    logic [31:0]            len_v;
    logic [31:0]            op0_v;
    logic [31:0]            op1_v;
    logic [31:0]            kinds_v;
    logic [31:0]            sels_v;
    expect_t                item;

    rst_n          = 1'b0;
    in_valid       = 1'b0;
    instr_bytes    = '0;
    form           = FORM_NONE;
    imm_1byte      = 1'b0;
    is_lea         = 1'b0;
    opnd0_is_write = 1'b0;
    opnd1_is_write = 1'b0;
    gpr            = '0;
    hint1          = '0;
    hint2          = '0;
    sent           = 0;
    have_regs      = 1'b0;

    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;

    // Nothing has been strobed yet, so the output stage must still be idle
    repeat (3) begin
      @(negedge clk);
      check("out_valid", 32'd0, 32'(out_valid));
      check("dest0_kind", 32'(DEST_NONE), 32'(dest0_kind));
      check("dest1_kind", 32'(DEST_NONE), 32'(dest1_kind));
    end

    fd = $fopen("verif/opnd_trace.txt", "r");
    if (fd == 0) begin
      abort_run("could not open the trace file verif/opnd_trace.txt");
    end

    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n <= 1 || line.getc(0) == "#") begin
        continue;
      end
      // The first data line is the register snapshot used by every instruction
      if (!have_regs) begin
        n = $sscanf(line, "%h %h %h %h %h %h %h %h", regs[0], regs[1], regs[2], regs[3],
                    regs[4], regs[5], regs[6], regs[7]);
        if (n != 8) begin
          abort_run("the register line of the trace is malformed");
        end
        for (int i = 0; i < 8; i++) begin
          gpr[i] = regs[i];
        end
        have_regs = 1'b1;
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h", bytes_v, form_v,
                  flags_v, hw_v, h1a_v, h1d_v, h2a_v, h2d_v, idle_v, len_v, op0_v, op1_v,
                  kinds_v, sels_v);
      if (n != 14) begin
        abort_run($sformatf("trace line %0d is malformed", sent + 1));
      end

      instr_bytes    = bytes_v;
      form           = opnd_form_e'(form_v[2:0]);
      imm_1byte      = flags_v[3];
      is_lea         = flags_v[2];
      opnd0_is_write = flags_v[1];
      opnd1_is_write = flags_v[0];
      hint1.is_write = hw_v[1];
      hint1.address  = h1a_v;
      hint1.data     = h1d_v;
      hint2.is_write = hw_v[0];
      hint2.address  = h2a_v;
      hint2.data     = h2d_v;
      in_valid       = 1'b1;

      // The DUT samples this at the next rising edge and the result shows three edges later
      item.cycle = cyc + 1 + LATENCY;
      item.len   = len_v[`OPND_LEN_W-1:0];
      item.op0   = op0_v;
      item.op1   = op1_v;
      item.k0    = kinds_v[3:2];
      item.k1    = kinds_v[1:0];
      item.s0    = sels_v[6:4];
      item.s1    = sels_v[2:0];
      pending.push_back(item);
      sent++;

      @(negedge clk);
      in_valid = 1'b0;
      repeat (idle_v) @(negedge clk);
    end
    $fclose(fd);

    waited = 0;
    while (pending.size() != 0 && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    // A couple of extra edges would catch a stray out_valid after the last result
    repeat (2) @(negedge clk);

    if (pending.size() != 0) begin
      abort_run($sformatf("timeout with %0d results never delivered", pending.size()));
    end else if (sent == 0) begin
      abort_run("the trace file held no instructions");
    end else begin
      $display("*** PASSED ***");
      $finish;
    end
  end

endmodule

// File: project.f
+incdir+verilog
verilog/opnd_pkg.sv
verilog/opnd_stage_if.sv
verilog/instr_field_extract.sv
verilog/opnd_address_gen.sv
verilog/opnd_hint_resolve.sv
verilog/decode_opnds.sv
verif/decode_opnds_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build the operand decoder testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary -j 0 -f project.f --top-module decode_opnds_tb -o sim_decode_opnds \
  && ./obj_dir/sim_decode_opnds | tee /dev/stderr | grep -qF '*** PASSED ***' \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
exit 0

// File: verif/opnd_trace.txt
# First data line: EAX ECX EDX EBX ESP EBP ESI EDI. Then: bytes(opcode low) form flags(imm1 lea
# wr0 wr1) hw(h1 h2) h1a h1d h2a h2d idle | expect len opnd0 opnd1 kinds(k0 k1) sels(s0 s1)
00001000 00002100 00003200 00004300 00005400 00006500 00007600 00008700
0000000000000000000053 1 2 0 00000000 00000000 00000000 00000000 2 0 00004300 00000000 4 30
000000000000000000D189 2 3 0 00000000 00000000 00000000 00000000 0 1 00002100 00003200 5 12
000000000000000000FE03 3 2 0 00000000 00000000 00000000 00000000 0 1 00008700 00007600 4 70
0000000000000000F0438B 3 2 0 000042F0 DEADBEEF 00000000 00000000 0 2 00001000 DEADBEEF 4 00
0000000000000001208D89 2 2 2 00006620 11111111 00006620 22222222 1 5 22222222 00002100 8 00
000000000000400000158B 3 2 0 00400000 55AA55AA 00000400 44444444 0 5 00003200 55AA55AA 4 20
0000000000000000800083 4 A 1 00001004 33333333 00001000 66666666 0 2 00000000 FFFFFF80 8 00
00000000000000088B448D 3 6 0 00000000 00000000 00000000 00000000 0 3 00001000 0000C708 4 00
00000000FFFFFF00E4948D 3 6 0 00000000 00000000 00000000 00000000 0 6 00003200 00005300 4 20
0000000000000010751C8D 3 6 0 00000000 00000000 00000000 00000000 0 6 00004300 0000EC10 4 30
0000000000001234567805 5 2 0 00000000 00000000 00000000 00000000 1 4 00001000 12345678 4 00
000000000000000000FE6A 6 8 0 00000000 00000000 00000000 00000000 0 1 FFFFFFFE 00000000 0 00
